// ==== design/rv_pkg.sv ====
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  localparam logic [xlen-1:0] reset_pc = '0;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl / sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra, srai

  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd3;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd4;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd8;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10; // lui

  // one instruction word, four ways to slice it
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] upper; // u immediate, or the shuffled j offset
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } uj;
  } rv_insn_u;

endpackage

// ==== design/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  rv_insn_u              insn,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output logic [xlen-1:0]       imm,
  output logic [alu_op_w-1:0]   alu_op,
  output logic                  alu_src_imm,
  output logic                  alu_src_pc,
  output logic                  reg_write,
  output logic                  is_branch,
  output logic [2:0]            br_funct3,
  output logic                  is_jal,
  output logic                  is_ecall,
  output logic                  illegal
);

  logic f7_zero;
  logic f7_alt;

  assign rs1       = insn.r.rs1;
  assign rs2       = insn.r.rs2;
  assign rd        = insn.r.rd;
  assign br_funct3 = insn.b.funct3;

  assign f7_zero = (insn.r.funct7 == 7'd0);
  assign f7_alt  = (insn.r.funct7 == funct7_alt);

  // same funct3 map for OP and OP-IMM, alt picks sub / sra
  function automatic logic [alu_op_w-1:0] map_op(input logic [2:0] f3, input logic alt);
    case (f3)
      f3_add:  map_op = alt ? alu_sub : alu_add;
      f3_sll:  map_op = alu_sll;
      f3_slt:  map_op = alu_slt;
      f3_sltu: map_op = alu_sltu;
      f3_xor:  map_op = alu_xor;
      f3_sr:   map_op = alt ? alu_sra : alu_srl;
      f3_or:   map_op = alu_or;
      default: map_op = alu_and;
    endcase
  endfunction

  always_comb begin
    imm         = '0;
    alu_op      = alu_add;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    reg_write   = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_ecall    = 1'b0;
    illegal     = 1'b0;
    case (insn.r.opcode)
      op_lui, op_auipc: begin
        imm         = {insn.uj.upper, 12'b0};
        alu_op      = (insn.r.opcode == op_lui) ? alu_pass_b : alu_add;
        alu_src_imm = 1'b1;
        alu_src_pc  = (insn.r.opcode == op_auipc);
        reg_write   = 1'b1;
      end
      op_jal: begin
        imm = {{11{insn.uj.upper[19]}}, insn.uj.upper[19], insn.uj.upper[7:0],
               insn.uj.upper[8], insn.uj.upper[18:9], 1'b0};
        is_jal    = 1'b1;
        reg_write = 1'b1; // link register gets pc+4
      end
      op_branch: begin
        imm = {{19{insn.b.imm12}}, insn.b.imm12, insn.b.imm11, insn.b.imm10_5,
               insn.b.imm4_1, 1'b0};
        is_branch = 1'b1;
        illegal   = !(insn.b.funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu});
      end
      op_imm: begin
        imm         = {{20{insn.i.imm[11]}}, insn.i.imm};
        alu_op      = map_op(insn.i.funct3, (insn.i.funct3 == f3_sr) && f7_alt); // no subi
        alu_src_imm = 1'b1;
        reg_write   = 1'b1;
        if (insn.i.funct3 == f3_sll) illegal = !f7_zero;
        if (insn.i.funct3 == f3_sr)  illegal = !(f7_zero || f7_alt);
      end
      op_reg: begin
        alu_op    = map_op(insn.r.funct3, f7_alt);
        reg_write = 1'b1;
        // alt encoding only exists for sub and sra
        illegal = !(f7_zero || (f7_alt && insn.r.funct3 inside {f3_add, f3_sr}));
      end
      op_system: begin
        is_ecall = ({insn.i.imm, insn.i.rs1, insn.i.funct3, insn.i.rd} == '0);
        illegal  = !is_ecall; // ebreak and csr ops are not implemented
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) reg_write = 1'b0;
  end

endmodule

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       wr_data,
  input  logic                  wr_en
);

  logic [xlen-1:0] regs [num_regs];

  // x0 is cleared by reset and never written after that
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && rd != '0) begin
      regs[rd] <= wr_data;
    end
  end

  // async read, old value on a same-cycle write
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  a_x0_read: assert property (
    @(posedge clk) disable iff (rst)
    (rs1 == '0) |-> (rs1_data == '0)
  ) else $error("read of x0 returned nonzero");

endmodule

// ==== design/rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  logic [xlen-1:0]     a,
  input  logic [xlen-1:0]     b,
  input  logic [alu_op_w-1:0] op,
  output logic [xlen-1:0]     result
);

  logic [4:0] shamt;

  assign shamt = b[4:0]; // upper bits of b are ignored for shifts

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $unsigned($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  // the decoder must only ever hand over one of the eleven codes
  always_comb begin
    a_op_defined: assert final (op inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                                           alu_xor, alu_srl, alu_sra, alu_or, alu_and,
                                           alu_pass_b})
      else $error("undefined alu op %h", op);
  end

endmodule

// ==== design/rv_pc_unit.sv ====
`timescale 1ns/1ps

module rv_pc_unit import rv_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] rs1_data,
  input  logic [xlen-1:0] rs2_data,
  input  logic [xlen-1:0] imm,
  input  logic            is_branch,
  input  logic [2:0]      br_funct3,
  input  logic            is_jal,
  input  logic            is_ecall,
  input  logic            illegal,
  output logic [xlen-1:0] pc,
  output logic            halt,
  output logic            running
);

  logic            br_taken;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] pc_target;
  logic [xlen-1:0] pc_next;

  always_comb begin
    case (br_funct3)
      f3_beq:  br_taken = (rs1_data == rs2_data);
      f3_bne:  br_taken = (rs1_data != rs2_data);
      f3_blt:  br_taken = ($signed(rs1_data) < $signed(rs2_data));
      f3_bge:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
      f3_bltu: br_taken = (rs1_data < rs2_data);
      f3_bgeu: br_taken = (rs1_data >= rs2_data);
      default: br_taken = 1'b0; // reserved, decoder flags it illegal
    endcase
  end

  assign pc_plus4  = pc + xlen'(4);
  assign pc_target = pc + imm;
  assign pc_next   = ((is_branch && br_taken) || is_jal) ? pc_target : pc_plus4;

  assign running = !halt && !rst;

  // the halting instruction keeps its own pc
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= reset_pc;
      halt <= 1'b0;
    end else if (running) begin
      if (is_ecall || illegal) begin
        halt <= 1'b1;
      end else begin
        pc <= pc_next;
      end
    end
  end

  // branch and jal offsets from the decoder must keep fetch aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== design/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [xlen-1:0]       insn,
  output logic [xlen-1:0]       pc,
  output logic                  halt,
  output logic                  illegal,
  output logic                  retire_valid,
  output logic [reg_addr_w-1:0] retire_rd,
  output logic [xlen-1:0]       retire_data
);

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic [alu_op_w-1:0]   alu_op;
  logic                  alu_src_imm;
  logic                  alu_src_pc;
  logic                  reg_write;
  logic                  is_branch;
  logic [2:0]            br_funct3;
  logic                  is_jal;
  logic                  is_ecall;
  logic                  running;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;
  logic [xlen-1:0]       op_a;
  logic [xlen-1:0]       op_b;
  logic [xlen-1:0]       alu_result;
  logic [xlen-1:0]       wr_data;

  rv_decode u_decode (
    .insn        (insn),
    .rs1         (rs1),
    .rs2         (rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_src_imm (alu_src_imm),
    .alu_src_pc  (alu_src_pc),
    .reg_write   (reg_write),
    .is_branch   (is_branch),
    .br_funct3   (br_funct3),
    .is_jal      (is_jal),
    .is_ecall    (is_ecall),
    .illegal     (illegal)
  );

  assign op_a    = alu_src_pc ? pc : rs1_data;   // auipc
  assign op_b    = alu_src_imm ? imm : rs2_data;
  assign wr_data = is_jal ? pc + xlen'(4) : alu_result; // link address for jal

  // nothing retires once halted or during reset
  assign retire_valid = reg_write && running;
  assign retire_rd    = rd;
  assign retire_data  = wr_data;

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd       (rd),
    .wr_data  (wr_data),
    .wr_en    (retire_valid)
  );

  rv_alu u_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (alu_op),
    .result (alu_result)
  );

  rv_pc_unit u_pc_unit (
    .clk       (clk),
    .rst       (rst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .is_branch (is_branch),
    .br_funct3 (br_funct3),
    .is_jal    (is_jal),
    .is_ecall  (is_ecall),
    .illegal   (illegal),
    .pc        (pc),
    .halt      (halt),
    .running   (running)
  );

endmodule

// ==== verif/rv_core_checks.svh ====
`ifndef RV_CORE_CHECKS_SVH
`define RV_CORE_CHECKS_SVH

// reports what went wrong and ends the run
task automatic abort_run(input string why);
  $display("%s", why);
  $display("TESTS FAILED");
  $fatal(1, "run aborted");
endtask

task automatic check_word(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
  end
endtask

task automatic check_reg(input string name, input logic [reg_addr_w-1:0] got,
                         input logic [reg_addr_w-1:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
  end
endtask

// single flags such as halt, illegal and retire_valid
task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    abort_run($sformatf("Error: %s got %h expected %h", name, got, exp));
  end
endtask

`endif

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int period   = 4;
  localparam int num_rows = 47;
  localparam int unsigned seed = 32'h12e1;

  typedef struct {
    bit                    do_reset; // pulse rst before this row
    bit                    fill;     // core is halted, drive a random lui word
    logic [xlen-1:0]       word;
    logic [xlen-1:0]       pc;
    bit                    halt;
    bit                    ill;
    bit                    rv;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
  } row_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic [xlen-1:0]       insn;
  logic [xlen-1:0]       pc;
  logic                  halt;
  logic                  illegal;
  logic                  retire_valid;
  logic [reg_addr_w-1:0] retire_rd;
  logic [xlen-1:0]       retire_data;

  row_t            rows [num_rows];
  int              row_cnt;
  logic [xlen-1:0] fill_mem [num_rows]; // words the core never executes

  `include "rv_core_checks.svh"

  rv_core u_dut (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .pc           (pc),
    .halt         (halt),
    .illegal      (illegal),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #(period / 2) clk = ~clk;

  // instruction encoders, operands in assembler order
  function automatic logic [xlen-1:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op_imm};
  endfunction

  function automatic logic [xlen-1:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [xlen-1:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic logic [xlen-1:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                             input logic [19:0] up);
    return {up, rd, opc};
  endfunction

  function automatic logic [xlen-1:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
  endfunction

  task automatic add_row(input bit do_reset, input bit fill, input logic [xlen-1:0] word,
                         input logic [xlen-1:0] at_pc, input bit halted, input bit ill,
                         input bit rv, input logic [reg_addr_w-1:0] rd,
                         input logic [xlen-1:0] data);
    if (row_cnt < num_rows) begin
      rows[row_cnt] = '{do_reset, fill, word, at_pc, halted, ill, rv, rd, data};
    end
    row_cnt++;
  endtask

  task automatic retire_row(input logic [xlen-1:0] word, input logic [xlen-1:0] at_pc,
                            input logic [reg_addr_w-1:0] rd, input logic [xlen-1:0] data);
    add_row(0, 0, word, at_pc, 0, 0, 1, rd, data);
  endtask

  task automatic quiet_row(input logic [xlen-1:0] word, input logic [xlen-1:0] at_pc);
    add_row(0, 0, word, at_pc, 0, 0, 0, '0, '0);
  endtask

  task automatic halted_row(input logic [xlen-1:0] at_pc);
    add_row(0, 1, '0, at_pc, 1, 0, 0, '0, '0);
  endtask

  task automatic illegal_after_reset(input logic [xlen-1:0] word);
    add_row(1, 0, word, reset_pc, 0, 1, 0, '0, '0);
  endtask

  task automatic build_table();
    retire_row(i_type(f3_add, 1, 0, 12'hffb), 0, 1, 32'hffff_fffb); // x1 = -5
    retire_row(i_type(f3_add, 2, 0, 12'h007), 4, 2, 32'h0000_0007);
    retire_row(i_type(f3_add, 3, 1, 12'h800), 8, 3, 32'hffff_f7fb); // most negative imm
    retire_row(i_type(f3_slt, 4, 1, 12'h003), 12, 4, 32'h1);
    retire_row(i_type(f3_sltu, 5, 1, 12'h003), 16, 5, 32'h0);      // -5 is huge unsigned
    retire_row(i_type(f3_sltu, 6, 2, 12'hfff), 20, 6, 32'h1);
    retire_row(i_type(f3_xor, 7, 1, 12'h0f0), 24, 7, 32'hffff_ff0b);
    retire_row(i_type(f3_or, 8, 2, 12'h700), 28, 8, 32'h0000_0707);
    retire_row(i_type(f3_and, 9, 1, 12'h0ff), 32, 9, 32'h0000_00fb);
    retire_row(i_type(f3_sll, 10, 1, 12'h004), 36, 10, 32'hffff_ffb0);
    retire_row(i_type(f3_sr, 11, 1, 12'h01c), 40, 11, 32'h0000_000f);
    retire_row(i_type(f3_sr, 12, 1, 12'h401), 44, 12, 32'hffff_fffd); // srai by 1
    retire_row(u_type(op_lui, 13, 20'h12345), 48, 13, 32'h1234_5000);
    retire_row(u_type(op_auipc, 14, 20'h00001), 52, 14, 32'h0000_1034);
    // register-register, shift amounts taken from the low five bits only
    retire_row(r_type(7'h00, f3_add, 15, 1, 2), 56, 15, 32'h2);
    retire_row(r_type(funct7_alt, f3_add, 16, 2, 1), 60, 16, 32'hc);
    retire_row(r_type(7'h00, f3_sll, 17, 2, 8), 64, 17, 32'h380);           // by 7
    retire_row(r_type(7'h00, f3_slt, 18, 1, 2), 68, 18, 32'h1);
    retire_row(r_type(7'h00, f3_sltu, 19, 1, 2), 72, 19, 32'h0);
    retire_row(r_type(7'h00, f3_xor, 20, 1, 2), 76, 20, 32'hffff_fffc);
    retire_row(r_type(7'h00, f3_sr, 21, 1, 10), 80, 21, 32'h0000_ffff);     // by 16
    retire_row(r_type(funct7_alt, f3_sr, 22, 1, 7), 84, 22, 32'hffff_ffff); // by 11
    retire_row(r_type(7'h00, f3_or, 23, 2, 13), 88, 23, 32'h1234_5007);
    retire_row(r_type(7'h00, f3_and, 24, 1, 13), 92, 24, 32'h1234_5000);
    retire_row(i_type(f3_add, 0, 2, 12'h005), 96, 0, 32'hc); // retires, x0 unchanged
    retire_row(r_type(7'h00, f3_add, 25, 0, 2), 100, 25, 32'h7);
    // branches, taken then not taken
    quiet_row(b_type(f3_beq, 4, 18, 13'd8), 104);
    quiet_row(b_type(f3_beq, 1, 2, 13'd8), 112);
    quiet_row(b_type(f3_bne, 1, 2, 13'd12), 116);
    quiet_row(b_type(f3_bne, 4, 18, 13'd8), 128);
    quiet_row(b_type(f3_blt, 1, 2, 13'd16), 132); // skips 136..144
    quiet_row(b_type(f3_blt, 2, 1, 13'd8), 148);
    quiet_row(b_type(f3_bge, 2, 1, 13'd8), 152);
    quiet_row(b_type(f3_bge, 1, 2, 13'd8), 160);
    quiet_row(b_type(f3_bltu, 2, 1, 13'd8), 164);
    quiet_row(b_type(f3_bltu, 1, 2, 13'd8), 172);
    quiet_row(b_type(f3_bgeu, 1, 2, 13'd12), 176);
    quiet_row(b_type(f3_bgeu, 2, 1, 13'd8), 188);
    retire_row(j_type(26, 21'h1f_ffc8), 192, 26, 32'd196); // jal back by 56
    retire_row(r_type(7'h00, f3_add, 27, 26, 2), 136, 27, 32'd203);
    quiet_row(32'h0000_0073, 140); // ecall
    halted_row(140);
    halted_row(140);
    illegal_after_reset(32'h0000_007f);                   // unknown opcode
    halted_row(reset_pc);
    illegal_after_reset(r_type(7'h01, f3_add, 3, 1, 2)); // reserved funct7
    halted_row(reset_pc);
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
    end
    rst = 1'b0;
  endtask

  initial begin
    #((num_rows + 20) * period);
    abort_run("simulation timed out before the stimulus table finished");
  end

  initial begin
    rst  = 1'b1;
    insn = '0;
    void'($urandom(seed));
    foreach (fill_mem[i]) begin
      fill_mem[i] = $urandom();
    end
    row_cnt = 0;
    build_table();
    if (row_cnt != num_rows) begin
      abort_run($sformatf("table holds %0d rows instead of %0d", row_cnt, num_rows));
    end
    apply_reset();
    foreach (rows[k]) begin
      if (rows[k].do_reset) apply_reset();
      check_word("pc", pc, rows[k].pc); // settled since the last rising edge
      check_bit("halt", halt, rows[k].halt);
      // random lui would write a register if the core were still running
      insn = rows[k].fill ? {fill_mem[k][xlen-1:7], op_lui} : rows[k].word;
      #1;
      check_bit("illegal", illegal, rows[k].ill);
      check_bit("retire_valid", retire_valid, rows[k].rv);
      if (rows[k].rv) begin
        check_reg("retire_rd", retire_rd, rows[k].rd);
        check_word("retire_data", retire_data, rows[k].data);
      end
      @(negedge clk);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+verif
design/rv_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_core.sv
verif/rv_core_tb.sv
